// File: Makefile
# Verilator simulation of the audio board wrapper

VERILATOR ?= verilator
TOP       ?= tb_board_top
FLAGS     ?= --binary --timing --assert
FILE_LIST ?= vlog.f
PASS_TEXT ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	out=$$(./obj_dir/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir

// File: source/board_pkg.sv
package board_pkg;

    //------------------------------------------------------------------------
    // Board widths

    localparam int w_key         = 2;                       // Push buttons
    localparam int w_sw          = 3;                       // Slide switches
    localparam int w_led         = 8;                       // Bar-graph LEDs

    //------------------------------------------------------------------------
    // Sample formats

    localparam int mic_width     = 24;                      // INMP441 word
    localparam int sound_width   = 16;                      // Codec word

    //------------------------------------------------------------------------
    // Microphone link timing

    localparam int mic_sck_half  = 4;                       // clk per sck half period
    localparam int mic_frame_sck = 64;                      // sck per ws frame
    localparam int mic_div_w     = $clog2(mic_sck_half);
    localparam int mic_bit_w     = $clog2(mic_frame_sck);   // MSB doubles as ws

    //------------------------------------------------------------------------
    // Codec link timing

    localparam int i2s_bclk_half = 4;                       // clk per bclk half period
    localparam int i2s_slot_bits = 16;                      // bclk per channel slot
    localparam int i2s_div_w     = $clog2(i2s_bclk_half);
    localparam int i2s_slot_w    = $clog2(i2s_slot_bits);
    localparam int i2s_bit_w     = i2s_slot_w + 1;          // Two slots per frame

    //------------------------------------------------------------------------
    // Level meter

    localparam int level_base    = 15;                      // First LED at 2**15
    localparam int level_w       = $clog2(w_led + 1);       // Counts 0..w_led

    // Board-facing vectors
    typedef logic        [w_key       - 1:0] key_t;         // Active high
    typedef logic        [w_sw        - 1:0] sw_t;
    typedef logic        [w_led       - 1:0] led_t;

    // Audio samples, two's complement
    typedef logic signed [mic_width   - 1:0] mic_sample_t;
    typedef logic signed [sound_width - 1:0] sound_sample_t;

endpackage

// File: source/board_specific_top.sv
`timescale 1ns/1ns

module board_specific_top
    import board_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  key_t  key_n,                          // Active low at the pins
    input  sw_t   sw,
    output led_t  led,

    // INMP441 microphone
    output logic  mic_sck,
    output logic  mic_ws,
    output logic  mic_lr,
    input  logic  mic_sd,

    // Audio codec
    output logic  i2s_mclk,
    output logic  i2s_bclk,
    output logic  i2s_lrclk,
    output logic  i2s_sdata
);

    //------------------------------------------------------------------------

    key_t          key;                           // Pressed reads as 1
    mic_sample_t   mic_value;
    logic          mic_valid;                     // One clk per mic frame
    sound_sample_t sound;                         // Level signal to codec

    assign key    = ~key_n;
    assign mic_lr = 1'b0;                         // Mic talks in the left slot

    //------------------------------------------------------------------------

    inmp441_mic_i2s_receiver i_microphone
    (
        .clk         ( clk        ),
        .rst         ( rst        ),
        .sd          ( mic_sd     ),
        .sck         ( mic_sck    ),
        .ws          ( mic_ws     ),
        .value       ( mic_value  ),
        .value_valid ( mic_valid  )
    );

    //------------------------------------------------------------------------

    lab_top i_lab_top
    (
        .clk         ( clk        ),
        .rst         ( rst        ),
        .key         ( key        ),
        .sw          ( sw         ),
        .mic         ( mic_value  ),
        .mic_valid   ( mic_valid  ),
        .led         ( led        ),
        .sound       ( sound      )
    );

    //------------------------------------------------------------------------

    i2s_audio_out o_audio
    (
        .clk         ( clk        ),
        .rst         ( rst        ),
        .data_in     ( sound      ),       // Sampled at each frame start
        .mclk        ( i2s_mclk   ),
        .bclk        ( i2s_bclk   ),
        .lrclk       ( i2s_lrclk  ),
        .sdata       ( i2s_sdata  )
    );

endmodule

// File: source/i2s_audio_out.sv
`timescale 1ns/1ns

module i2s_audio_out
    import board_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  sound_sample_t data_in,      // Sampled at each frame start
    output logic          mclk,         // clk / 2
    output logic          bclk,
    output logic          lrclk,        // Low is the left slot
    output logic          sdata
);

    logic [i2s_div_w - 1:0] div_cnt;
    logic [i2s_bit_w - 1:0] bit_cnt;    // bclk period inside the frame
    logic                   bclk_tick;
    logic                   bclk_fall;
    logic                   frame_start;
    logic                   msb_out;
    sound_sample_t          sample;     // Word for both slots
    sound_sample_t          shift_reg;

    //------------------------------------------------------------------------
    // Clock dividers

    assign bclk_tick = (div_cnt == i2s_div_w'(i2s_bclk_half - 1));
    assign bclk_fall = bclk_tick & bclk;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            mclk    <= 1'b0;
            div_cnt <= '0;
            bclk    <= 1'b0;
        end
        else
        begin
            mclk <= ~mclk;
            if (bclk_tick)
            begin
                div_cnt <= '0;
                bclk    <= ~bclk;
            end
            else
                div_cnt <= div_cnt + 1'b1;
        end
    end

    //------------------------------------------------------------------------
    // Slot sequencing, all on falling bclk

    assign frame_start = bclk_fall && (bit_cnt == i2s_bit_w'(2 * i2s_slot_bits - 1));
    assign msb_out     = bclk_fall && (bit_cnt[i2s_slot_w - 1:0] == '0);  // One bclk late

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (bclk_fall)
            bit_cnt <= bit_cnt + 1'b1;
    end

    assign lrclk = bit_cnt[i2s_bit_w - 1];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            sample    <= '0;        // Silence until the first frame
            shift_reg <= '0;
            sdata     <= 1'b0;
        end
        else
        begin
            if (frame_start)
                sample <= data_in;  // lrclk falls on this clk

            if (msb_out)
            begin
                sdata     <= sample[sound_width - 1];
                shift_reg <= {sample[sound_width - 2:0], 1'b0};
            end
            else if (bclk_fall)
            begin
                sdata     <= shift_reg[sound_width - 1];  // LSB spills into next slot
                shift_reg <= {shift_reg[sound_width - 2:0], 1'b0};
            end
        end
    end

endmodule

// File: source/inmp441_mic_i2s_receiver.sv
`timescale 1ns/1ns

module inmp441_mic_i2s_receiver
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sd,             // Mic data, changes on falling sck
    output logic        sck,
    output logic        ws,             // Low selects the left slot
    output mic_sample_t value,
    output logic        value_valid     // One clk per frame
);

    logic [mic_div_w - 1:0] div_cnt;
    logic [mic_bit_w - 1:0] bit_cnt;    // sck period inside the frame
    logic                   sck_tick;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   capture_en;
    logic                   capture_last;
    logic                   capture_done;
    mic_sample_t            shift_reg;

    //------------------------------------------------------------------------
    // sck generation

    assign sck_tick = (div_cnt == mic_div_w'(mic_sck_half - 1));
    assign sck_rise = sck_tick & ~sck;  // sck goes high this clk
    assign sck_fall = sck_tick &  sck;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            div_cnt <= '0;
            sck     <= 1'b0;
        end
        else if (sck_tick)
        begin
            div_cnt <= '0;
            sck     <= ~sck;
        end
        else
            div_cnt <= div_cnt + 1'b1;
    end

    //------------------------------------------------------------------------
    // Frame position, advanced on falling sck

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            bit_cnt <= '0;
        else if (sck_fall)
            bit_cnt <= bit_cnt + 1'b1;  // Wraps every frame
    end

    assign ws = bit_cnt[mic_bit_w - 1]; // Upper half is the right slot

    //------------------------------------------------------------------------
    // Capture, bits 1..24 of the left slot

    assign capture_en   = sck_rise && (bit_cnt >= mic_bit_w'(1))
                                   && (bit_cnt <= mic_bit_w'(mic_width));
    assign capture_last = sck_rise && (bit_cnt == mic_bit_w'(mic_width));

    always_ff @(posedge clk)
    begin
        if (capture_en)
            shift_reg <= {shift_reg[mic_width - 2:0], sd};  // MSB first
        if (capture_done)
            value <= shift_reg;
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            capture_done <= 1'b0;
            value_valid  <= 1'b0;
        end
        else
        begin
            capture_done <= capture_last;   // LSB now in shift_reg
            value_valid  <= capture_done;   // Same clk as value update
        end
    end

endmodule

// File: source/lab_top.sv
`timescale 1ns/1ns

module lab_top
    import board_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  key_t          key,             // key[0] mutes the sound
    input  sw_t           sw,              // sw[0] freezes the bar graph
    input  mic_sample_t   mic,
    input  logic          mic_valid,       // Single-cycle strobe

    output led_t          led,
    output sound_sample_t sound
);

    mic_sample_t                mic_abs;
    logic [mic_width   - 2:0] magnitude;   // Saturated |mic|
    logic [level_w     - 1:0] level;       // Thresholds passed
    led_t                       bar;

    //------------------------------------------------------------------------
    // Level meter

    always_comb
    begin
        mic_abs   = mic[mic_width - 1] ? -mic : mic;
        magnitude = mic_abs[mic_width - 1] ? '1 : mic_abs[mic_width - 2:0];  // -2**23 case
    end

    always_comb
    begin
        level = '0;
        for (int k = 1; k <= w_led; k++)
        begin
            if (magnitude >= ((mic_width - 1)'(1) << (level_base + k - 1)))
                level = level + 1'b1;
        end
    end

    // Thermometer code, lowest LEDs first
    always_comb
    begin
        for (int i = 0; i < w_led; i++)
            bar[i] = (i < level);
    end

    //------------------------------------------------------------------------

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            led   <= '0;
            sound <= '0;
        end
        else if (mic_valid)
        begin
            if (!sw[0])                                     // Freeze holds led
                led <= bar;
            sound <= key[0] ? '0 : mic[mic_width - 1 -: sound_width];  // Top 16 bits
        end
    end

endmodule

// File: verification/board_top_checker.sv
`timescale 1ns/1ns

module board_top_checker
    import board_pkg::*;
(
    input logic clk,
    input logic rst,
    input logic mic_valid,
    input logic mic_sck,
    input logic mic_ws,
    input logic i2s_bclk,
    input logic i2s_lrclk,
    input led_t led
);

    led_t led_plus_one;                                      // Power of two for a thermometer
    int   error_count = 0;                                   // Assertion failures so far

    assign led_plus_one = led + 1'b1;

    //------------------------------------------------------------------------

    mic_valid_single: assert property (@(posedge clk) disable iff (rst)
        mic_valid |=> !mic_valid)
        else
        begin
            error_count++;
            $error("mic_valid high in two consecutive cycles");
        end

    mic_ws_on_sck_fall: assert property (@(posedge clk) disable iff (rst)
        (mic_ws != $past(mic_ws)) |-> ($past(mic_sck) && !mic_sck))
        else
        begin
            error_count++;
            $error("mic_ws changed away from a falling sck");
        end

    lrclk_on_bclk_fall: assert property (@(posedge clk) disable iff (rst)
        (i2s_lrclk != $past(i2s_lrclk)) |-> ($past(i2s_bclk) && !i2s_bclk))
        else
        begin
            error_count++;
            $error("i2s_lrclk changed away from a falling bclk");
        end

    led_thermometer: assert property (@(posedge clk) disable iff (rst)
        (led & led_plus_one) == '0)
        else
        begin
            error_count++;
            $error("led is not a thermometer pattern");
        end

endmodule

bind board_specific_top board_top_checker board_top_checker_i
(
    .clk       ( clk       ),
    .rst       ( rst       ),
    .mic_valid ( mic_valid ),
    .mic_sck   ( mic_sck   ),
    .mic_ws    ( mic_ws    ),
    .i2s_bclk  ( i2s_bclk  ),
    .i2s_lrclk ( i2s_lrclk ),
    .led       ( led       )
);

// File: verification/tb_board_top.sv
`timescale 1ns/1ns

module tb_board_top
    import board_pkg::*;
();

    localparam int     n_fixed     = 8;                          // Hand-written rows
    localparam int     n_rows      = 16;
    localparam int     clk_period  = 8;
    localparam int     frame_clk   = 2 * mic_sck_half * mic_frame_sck;  // 512 clk
    localparam longint watchdog_ns = longint'(n_rows + 2) * 4 * frame_clk * clk_period;

    logic          clk    = 1'b0;
    logic          rst;
    key_t          key_n;
    sw_t           sw;
    logic          mic_sd = 1'b0;
    led_t          led;
    logic          mic_sck;
    logic          mic_ws;
    logic          mic_lr;
    logic          i2s_mclk;
    logic          i2s_bclk;
    logic          i2s_lrclk;
    logic          i2s_sdata;

    logic [31:0]   lfsr       = 32'hd0b6_cf79;

    // Stimulus table
    mic_sample_t   row_sample [n_rows];
    key_t          row_key_n  [n_rows];
    sw_t           row_sw     [n_rows];
    led_t          row_led    [n_rows];                          // Expected bar graph
    sound_sample_t row_sound  [n_rows];                          // Expected codec word

    always #(clk_period / 2) clk = ~clk;

    board_specific_top board_specific_top_i
    (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .key_n     ( key_n     ),
        .sw        ( sw        ),
        .led       ( led       ),
        .mic_sck   ( mic_sck   ),
        .mic_ws    ( mic_ws    ),
        .mic_lr    ( mic_lr    ),
        .mic_sd    ( mic_sd    ),
        .i2s_mclk  ( i2s_mclk  ),
        .i2s_bclk  ( i2s_bclk  ),
        .i2s_lrclk ( i2s_lrclk ),
        .i2s_sdata ( i2s_sdata )
    );

    //------------------------------------------------------------------------
    // Microphone model, new bit after each falling sck

    mic_sample_t   cur_sample;                                   // Set by the main process
    mic_sample_t   mic_word;                                     // Word of this frame
    logic          sck_prev;
    logic          ws_prev;
    int            mic_pos;                                      // sck period since ws fell

    always @(negedge clk)
    begin
        if (rst)
        begin
            sck_prev = 1'b0;
            ws_prev  = 1'b0;
            mic_pos  = 0;
            mic_word = '0;
            mic_sd   = 1'b0;
        end
        else
        begin
            if (sck_prev && !mic_sck)
            begin
                if (ws_prev && !mic_ws)
                    mic_pos = 0;                                 // Left slot begins
                else
                    mic_pos = mic_pos + 1;
                if (mic_pos == 0)
                    mic_word = cur_sample;
                if (!mic_ws && mic_pos >= 1 && mic_pos <= mic_width)
                    mic_sd = mic_word[mic_width - mic_pos];      // MSB at position 1
                else
                    mic_sd = 1'b0;                               // Zeros in the right slot
                ws_prev = mic_ws;
            end
            sck_prev = mic_sck;
        end
    end

    //------------------------------------------------------------------------
    // I2S decoder, sdata read on rising bclk

    int            clk_count;                                    // clk edges since reset
    logic          bclk_prev;
    logic          lr_prev;
    int            dec_idx;                                      // bclk since lrclk fell
    int            right_bits;
    sound_sample_t left_acc;
    sound_sample_t right_acc;
    sound_sample_t decoded_left  = '0;
    sound_sample_t decoded_right = '0;
    int            left_count    = 0;
    int            right_count   = 0;

    always @(posedge clk)
    begin
        if (rst)
        begin
            clk_count  = 0;
            bclk_prev  = 1'b0;
            lr_prev    = 1'b0;
            dec_idx    = -1;                                     // First bclk is position 0
            right_bits = 0;
            left_acc   = '0;
            right_acc  = '0;
        end
        else
        begin
            clk_count++;
            if (!bclk_prev && i2s_bclk)
            begin
                if (lr_prev && !i2s_lrclk)
                    dec_idx = 0;
                else
                    dec_idx = dec_idx + 1;
                lr_prev = i2s_lrclk;
                if (dec_idx >= 1 && dec_idx <= i2s_slot_bits)
                begin
                    left_acc = {left_acc[sound_width - 2:0], i2s_sdata};
                    if (dec_idx == i2s_slot_bits)            // LSB sits in the right slot
                    begin
                        decoded_left = left_acc;
                        left_count++;
                    end
                end
                else
                begin
                    if (dec_idx == i2s_slot_bits + 1)
                        right_bits = 0;                          // Right MSB
                    right_acc = {right_acc[sound_width - 2:0], i2s_sdata};
                    right_bits++;
                    if (dec_idx == 0 && right_bits == sound_width)
                    begin
                        decoded_right = right_acc;
                        right_count++;
                    end
                end
            end
            bclk_prev = i2s_bclk;
        end
    end

    //------------------------------------------------------------------------
    // Expected values from the level and sound rules

    function automatic led_t level_leds(input mic_sample_t sample);
        longint mag;
        int     count;
        mag = longint'(sample);
        if (mag < 0)
            mag = -mag;
        if (mag > (longint'(1) << (mic_width - 1)) - 1)
            mag = (longint'(1) << (mic_width - 1)) - 1;      // Saturate to 23 bits
        count = 0;
        for (int k = 1; k <= w_led; k++)
            if (mag >= (longint'(1) << (level_base + k - 1)))
                count++;
        return led_t'((1 << count) - 1);                     // Thermometer
    endfunction

    function automatic sound_sample_t sound_for(input mic_sample_t sample, input key_t keys_n);
        if (!keys_n[0])
            return '0;                                       // Muted
        return sound_sample_t'(sample >>> (mic_width - sound_width));
    endfunction

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_step();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
            value = {value[30:0], lfsr_step()};
        return value;
    endfunction

    //------------------------------------------------------------------------

    task automatic set_row(input int idx, input mic_sample_t sample, input key_t kn,
                           input sw_t s, input led_t exp_led, input sound_sample_t exp_sound);
        row_sample[idx] = sample;
        row_key_n[idx]  = kn;
        row_sw[idx]     = s;
        row_led[idx]    = exp_led;
        row_sound[idx]  = exp_sound;
    endtask

    task automatic build_table();
        set_row(0, 24'h008000, 2'b11, 3'b000, 8'h01, 16'h0080);  // At 2**15
        set_row(1, 24'h007fff, 2'b11, 3'b000, 8'h00, 16'h007f);  // Just below
        set_row(2, 24'h400000, 2'b11, 3'b000, 8'hff, 16'h4000);  // Top threshold
        set_row(3, 24'h3fffff, 2'b11, 3'b000, 8'h7f, 16'h3fff);
        set_row(4, 24'h800000, 2'b11, 3'b000, 8'hff, 16'h8000);  // Most negative
        set_row(5, 24'h010001, 2'b10, 3'b000, 8'h03, 16'h0000);  // Muted
        set_row(6, 24'hf00000, 2'b11, 3'b001, 8'h03, 16'hf000);  // Frozen bar
        set_row(7, 24'hffc000, 2'b11, 3'b110, 8'h00, 16'hffc0);  // Unused switches
        for (int i = n_fixed; i < n_rows; i++)
        begin
            row_sample[i] = mic_sample_t'(random_bits(mic_width));
            row_key_n[i]  = key_t'(random_bits(w_key));
            row_sw[i]     = sw_t'(random_bits(w_sw));
            row_led[i]    = row_sw[i][0] ? row_led[i - 1] : level_leds(row_sample[i]);
            row_sound[i]  = sound_for(row_sample[i], row_key_n[i]);
        end
    endtask

    // Ends mid-frame, clear of the model's frame start
    task automatic wait_mic_frames(input int frames);
        repeat (frames) @(negedge mic_ws);
        @(posedge mic_sck);
        @(negedge clk);
    endtask

    task automatic check_led(input string name, input led_t expected, input led_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "wrong bar graph value");
        end
    endtask

    task automatic check_sound(input string name, input sound_sample_t expected,
                               input sound_sample_t actual);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t ns: %s expected %h, got %h",
                     $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "wrong codec word");
        end
    endtask

    task automatic check_pin(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t ns: %s expected %b, got %b",
                     $time, name, expected, actual);
            $display("tests failed");
            $fatal(1, "wrong pin level");
        end
    endtask

    // mclk is clk / 2, so two neighbouring clk show both phases
    task automatic check_mclk(input string name);
        check_pin(name, clk_count[0], i2s_mclk);
        @(negedge clk);
        check_pin(name, clk_count[0], i2s_mclk);
    endtask

    //------------------------------------------------------------------------

    initial
    begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns, the run hung", watchdog_ns);
        $display("tests failed");
        $fatal(1, "timeout");
    end

    initial
    begin
        rst        = 1'b1;
        key_n      = '1;                                     // Keys released
        sw         = '0;
        cur_sample = '0;
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_led("led after reset", '0, led);
        check_pin("mic_lr after reset", 1'b0, mic_lr);
        check_pin("i2s_mclk after reset", 1'b0, i2s_mclk);
        wait (left_count > 0 && right_count > 0);            // One full codec frame
        @(negedge clk);
        check_led("led after reset", '0, led);
        check_sound("left word after reset", '0, decoded_left);
        check_sound("right word after reset", '0, decoded_right);
        wait_mic_frames(1);

        for (int i = 0; i < n_rows; i++)
        begin
            cur_sample = row_sample[i];
            key_n      = row_key_n[i];
            sw         = row_sw[i];
            wait_mic_frames(3);
            check_led($sformatf("led row %0d", i), row_led[i], led);
            check_sound($sformatf("left word row %0d", i), row_sound[i], decoded_left);
            check_sound($sformatf("right word row %0d", i), row_sound[i], decoded_right);
            check_pin($sformatf("mic_lr row %0d", i), 1'b0, mic_lr);
            check_mclk($sformatf("i2s_mclk row %0d", i));
        end

        if (board_specific_top_i.board_top_checker_i.error_count == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
        begin
            $display("tests failed");
            $fatal(1, "protocol assertions failed");
        end
    end

endmodule

// File: vlog.f
source/board_pkg.sv
source/inmp441_mic_i2s_receiver.sv
source/lab_top.sv
source/i2s_audio_out.sv
source/board_specific_top.sv
verification/board_top_checker.sv
verification/tb_board_top.sv
